/* design/bit_packer.sv */
`timescale 1ns/100ps

module bit_packer #(
    parameter int count_width = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   enable,
    input  logic                   bit1,
    input  logic                   flush,
    output logic                   byte_valid,
    output huff_pkg::byte_t        byte_data,
    output logic [count_width-1:0] bit_count,
    output logic                   flush_done
);

    // newest bit sits in the lsb
    huff_pkg::byte_t acc;
    huff_pkg::byte_t acc_shifted;
    huff_pkg::byte_t padded;

    // bits held in acc, 0 means empty
    logic [2:0] fill;
    logic [3:0] pad_shift;

    logic flush_pend;
    logic flush_go;
    logic flush_ack;

    assign acc_shifted = {acc[6:0], bit1};

    // left-justify a partial byte, zeros fill the tail
    assign pad_shift = 4'd8 - {1'b0, fill};
    assign padded    = acc << pad_shift;

    // flush waits for a cycle with no incoming bit
    assign flush_go = (flush || flush_pend) && !enable;

    always_ff @(posedge clk) begin
        if (rst) begin
            fill       <= 3'd0;
            byte_valid <= 1'b0;
            bit_count  <= '0;
            flush_pend <= 1'b0;
            flush_ack  <= 1'b0;
            flush_done <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            flush_pend <= (flush || flush_pend) && enable;
            // done strobe trails the padded byte by one cycle
            flush_ack  <= flush_go;
            flush_done <= flush_ack;
            if (enable) begin
                // fill wraps to 0 on the eighth bit
                fill      <= fill + 3'd1;
                bit_count <= bit_count + 1'b1;
                if (fill == 3'd7) begin
                    byte_valid <= 1'b1;
                end
            end else if (flush_go) begin
                fill <= 3'd0;
                // nothing pending, no byte
                if (fill != 3'd0) begin
                    byte_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            acc <= acc_shifted;
            if (fill == 3'd7) begin
                byte_data <= acc_shifted;
            end
        end else if (flush_go && (fill != 3'd0)) begin
            byte_data <= padded;
        end
    end

endmodule

/* design/header_synthesis.sv */
`timescale 1ns/100ps

module header_synthesis (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 char_found,
    input  huff_pkg::char_t      char_index,
    input  logic                 curr_path,
    input  huff_pkg::track_len_t track_length,
    input  logic                 state_3,
    input  logic                 left,
    input  huff_pkg::lefts_t     num_lefts,
    output logic                 enable,
    output logic                 bit1,
    output logic                 busy
);

    huff_pkg::hdr_state_t state;
    huff_pkg::hdr_state_t state_next;

    // field being sent, msb leaves first
    logic [8:0] shreg;
    logic [8:0] shreg_next;

    // bits of the current field already issued
    logic [3:0] cnt;
    logic [3:0] cnt_next;

    // left-count field captured with the character
    huff_pkg::lefts_t lefts_q;
    logic             lefts_pend;

    logic char_take;
    logic backtrack_req;
    logic field_done;
    logic shift_out;
    logic enable_next;
    logic bit1_next;
    logic busy_next;

    // a character is only taken between fields
    assign char_take = char_found && (state == huff_pkg::hs_idle);

    // one zero per backtrack cycle, never during a character
    assign backtrack_req = state_3 && curr_path && (track_length != '0) &&
                           !char_found && (state == huff_pkg::hs_idle);

    // all 9 bits of a field issued, last one on the output now
    assign field_done = (cnt == 4'd9);

    always_comb begin
        state_next  = state;
        shreg_next  = shreg;
        cnt_next    = cnt;
        busy_next   = busy;
        shift_out   = 1'b0;
        enable_next = 1'b0;
        bit1_next   = 1'b0;

        case (state)
            huff_pkg::hs_idle: begin
                if (char_take) begin
                    // leading 1 marks a leaf, then the index
                    state_next = huff_pkg::hs_load;
                    shreg_next = {1'b1, char_index};
                    cnt_next   = 4'd0;
                    busy_next  = 1'b1;
                end else if (backtrack_req) begin
                    enable_next = 1'b1;
                    bit1_next   = 1'b0;
                end
            end

            huff_pkg::hs_load: begin
                // first bit of the character field
                shift_out  = 1'b1;
                state_next = huff_pkg::hs_char;
            end

            huff_pkg::hs_char: begin
                if (!field_done) begin
                    shift_out = 1'b1;
                end else if (lefts_pend) begin
                    // left leaf, queue the count field behind an idle cycle
                    state_next = huff_pkg::hs_gap;
                    shreg_next = {1'b1, lefts_q};
                    cnt_next   = 4'd0;
                end else begin
                    state_next = huff_pkg::hs_idle;
                    busy_next  = 1'b0;
                end
            end

            huff_pkg::hs_gap: begin
                // leading 1 of the count field
                shift_out  = 1'b1;
                state_next = huff_pkg::hs_lefts;
            end

            huff_pkg::hs_lefts: begin
                if (!field_done) begin
                    shift_out = 1'b1;
                end else begin
                    state_next = huff_pkg::hs_idle;
                    busy_next  = 1'b0;
                end
            end

            default: begin
                state_next = huff_pkg::hs_idle;
                busy_next  = 1'b0;
            end
        endcase

        // common shift step for both fields
        if (shift_out) begin
            enable_next = 1'b1;
            bit1_next   = shreg[8];
            shreg_next  = {shreg[7:0], 1'b0};
            cnt_next    = cnt + 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= huff_pkg::hs_idle;
            cnt        <= 4'd0;
            enable     <= 1'b0;
            bit1       <= 1'b0;
            busy       <= 1'b0;
            lefts_pend <= 1'b0;
        end else begin
            state  <= state_next;
            cnt    <= cnt_next;
            enable <= enable_next;
            bit1   <= bit1_next;
            busy   <= busy_next;
            // walker moves on after the strobe, so keep the decision
            if (char_take) begin
                lefts_pend <= left && (num_lefts != '0);
            end
        end
    end

    always_ff @(posedge clk) begin
        shreg <= shreg_next;
        if (char_take) begin
            lefts_q <= num_lefts;
        end
    end

endmodule

/* design/header_top.sv */
`timescale 1ns/100ps

module header_top #(
    parameter int count_width = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   char_found,
    input  huff_pkg::char_t        char_index,
    input  logic                   curr_path,
    input  huff_pkg::track_len_t   track_length,
    input  logic                   state_3,
    input  logic                   left,
    input  huff_pkg::lefts_t       num_lefts,
    input  logic                   flush,
    output logic                   busy,
    output logic                   byte_valid,
    output huff_pkg::byte_t        byte_data,
    output logic [count_width-1:0] bit_count,
    output logic                   flush_done
);

    // serial header stream between the stages
    logic stream_en;
    logic stream_bit;

    // walker events to bit stream
    header_synthesis synth0 (
        .clk          (clk),
        .rst          (rst),
        .char_found   (char_found),
        .char_index   (char_index),
        .curr_path    (curr_path),
        .track_length (track_length),
        .state_3      (state_3),
        .left         (left),
        .num_lefts    (num_lefts),
        .enable       (stream_en),
        .bit1         (stream_bit),
        .busy         (busy)
    );

    // bit stream to bytes, msb first
    bit_packer #(
        .count_width (count_width)
    ) pack0 (
        .clk        (clk),
        .rst        (rst),
        .enable     (stream_en),
        .bit1       (stream_bit),
        .flush      (flush),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .bit_count  (bit_count),
        .flush_done (flush_done)
    );

endmodule

/* design/huff_pkg.sv */
package huff_pkg;

    // character index of a leaf in the code tree
    typedef logic [7:0] char_t;

    // depth of the walker's current path
    typedef logic [6:0] track_len_t;

    // left turns recorded for a left leaf
    typedef logic [7:0] lefts_t;

    // one packed header byte
    typedef logic [7:0] byte_t;

    // header writer FSM
    typedef enum logic [2:0] {
        hs_idle,
        hs_load,
        hs_char,
        hs_gap,
        hs_lefts
    } hdr_state_t;

endpackage

/* dv/header_asserts.sv */
`timescale 1ns/100ps

module header_asserts (
    input logic                 clk,
    input logic                 rst,
    input huff_pkg::hdr_state_t state,
    input logic                 enable,
    input logic                 backtrack_req,
    input logic                 busy,
    input logic                 byte_valid,
    input logic                 flush_done
);

    // a zero bit in idle only answers a backtrack request
    idle_enable_from_backtrack: assert property (
        @(posedge clk) disable iff (rst)
        (enable && (state == huff_pkg::hs_idle)) |-> $past(backtrack_req)
    ) else $error("enable high in idle with no backtrack request before it");

    // walker may send right after reset
    busy_low_after_reset: assert property (
        @(posedge clk) rst |=> !busy
    ) else $error("busy high in the cycle after reset");

    // strobes last one cycle
    byte_valid_pulse: assert property (
        @(posedge clk) disable iff (rst) byte_valid |=> !byte_valid
    ) else $error("byte_valid held for more than one cycle");

    flush_done_pulse: assert property (
        @(posedge clk) disable iff (rst) flush_done |=> !flush_done
    ) else $error("flush_done held for more than one cycle");

endmodule

// synthesis side, packer strobes tied quiet
bind header_synthesis header_asserts synth_chk (
    .clk (clk), .rst (rst), .state (state), .enable (enable),
    .backtrack_req (backtrack_req), .busy (busy),
    .byte_valid (1'b0), .flush_done (1'b0)
);

// packer side, no FSM here
bind bit_packer header_asserts pack_chk (
    .clk (clk), .rst (rst), .state (huff_pkg::hs_idle), .enable (1'b0),
    .backtrack_req (1'b0), .busy (1'b0),
    .byte_valid (byte_valid), .flush_done (flush_done)
);

/* dv/header_tb.sv */
`timescale 1ns/100ps

module header_tb;

    localparam int count_width = 16;
    localparam int wait_limit  = 50;

    // entry kinds
    localparam int k_char  = 0;
    localparam int k_back  = 1;
    localparam int k_flush = 2;

    logic                   clk;
    logic                   rst;
    logic                   char_found;
    huff_pkg::char_t        char_index;
    logic                   curr_path;
    huff_pkg::track_len_t   track_length;
    logic                   state_3;
    logic                   left;
    huff_pkg::lefts_t       num_lefts;
    logic                   flush;
    logic                   busy;
    logic                   byte_valid;
    huff_pkg::byte_t        byte_data;
    logic [count_width-1:0] bit_count;
    logic                   flush_done;

    // event table, one slot per entry in each queue
    string            tbl_name[$];
    int               tbl_kind[$];
    huff_pkg::char_t  tbl_char[$];
    logic             tbl_left[$];
    huff_pkg::lefts_t tbl_lefts[$];
    // backtrack level held through a character
    logic             tbl_noise[$];

    // reference stream, bit and owning entry
    logic  exp_bits[$];
    string exp_owner[$];
    int    model_count;

    int     errors;
    int     checks;
    integer seed;

    // set once a wait runs out, stops the table
    logic timed_out;

    // collector scratch
    huff_pkg::byte_t col_exp;
    string           col_owner;

    header_top #(
        .count_width (count_width)
    ) dut0 (
        .clk (clk), .rst (rst), .char_found (char_found), .char_index (char_index),
        .curr_path (curr_path), .track_length (track_length), .state_3 (state_3),
        .left (left), .num_lefts (num_lefts), .flush (flush), .busy (busy),
        .byte_valid (byte_valid), .byte_data (byte_data), .bit_count (bit_count),
        .flush_done (flush_done)
    );

    always #4 clk = ~clk;

    function automatic void add_entry(string name, int kind, huff_pkg::char_t idx,
                                      logic lft, huff_pkg::lefts_t nl, logic noise);
        tbl_name.push_back(name);
        tbl_kind.push_back(kind);
        tbl_char.push_back(idx);
        tbl_left.push_back(lft);
        tbl_lefts.push_back(nl);
        tbl_noise.push_back(noise);
    endfunction

    function automatic void build_table();
        int r;
        for (int i = 0; i < 8; i++) begin
            add_entry("backtrack_byte", k_back, 8'h00, 1'b0, 8'h00, 1'b0);
        end
        add_entry("flush_empty", k_flush, 8'h00, 1'b0, 8'h00, 1'b0);
        // 0x41 and 7 zeros, A0 80
        add_entry("char_41", k_char, 8'h41, 1'b0, 8'h00, 1'b0);
        for (int i = 0; i < 7; i++) begin
            add_entry("char_41_tail", k_back, 8'h00, 1'b0, 8'h00, 1'b0);
        end
        add_entry("flush_41", k_flush, 8'h00, 1'b0, 8'h00, 1'b0);
        add_entry("left_char", k_char, 8'h9c, 1'b1, 8'h05, 1'b0);
        add_entry("left_zero", k_char, 8'h3e, 1'b1, 8'h00, 1'b0);
        add_entry("noisy_left", k_char, 8'h77, 1'b1, 8'h81, 1'b1);
        add_entry("noisy_plain", k_char, 8'hc3, 1'b0, 8'h10, 1'b1);
        // 54 bits, last byte padded
        add_entry("flush_partial", k_flush, 8'h00, 1'b0, 8'h00, 1'b0);
        for (int i = 0; i < 20; i++) begin
            r = $random(seed);
            add_entry($sformatf("rand_char_%0d", i), k_char, r[7:0], r[8],
                      (r[21:20] == 2'd0) ? 8'h00 : r[19:12], r[27]);
            for (int j = 0; j < int'(r[25:24]); j++) begin
                add_entry($sformatf("rand_back_%0d", i), k_back, 8'h00, 1'b0, 8'h00, 1'b0);
            end
        end
        add_entry("flush_final", k_flush, 8'h00, 1'b0, 8'h00, 1'b0);
    endfunction

    // one field into the reference stream, msb first
    function automatic void push_field(logic [8:0] f, string name);
        for (int i = 8; i >= 0; i--) begin
            exp_bits.push_back(f[i]);
            exp_owner.push_back(name);
        end
        model_count += 9;
    endfunction

    task automatic close_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic wait_idle(string name);
        int n;
        n = 0;
        while ((busy !== 1'b0) && (n < wait_limit)) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (busy !== 1'b0) begin
            $display("busy stayed high for %0d cycles at entry %s", wait_limit, name);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_flush_done(string name);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && (n < wait_limit)) begin
            @(posedge clk);
            #1;
            n++;
            seen = (flush_done === 1'b1);
        end
        if (!seen) begin
            $display("flush_done never came after flush at entry %s", name);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic apply_entry(int i);
        logic [count_width-1:0] exp_count;
        wait_idle(tbl_name[i]);
        if (timed_out) begin
            return;
        end
        case (tbl_kind[i])
            k_char: begin
                char_found = 1'b1;
                char_index = tbl_char[i];
                left       = tbl_left[i];
                num_lefts  = tbl_lefts[i];
                if (tbl_noise[i]) begin
                    // same cycle as char_found and through busy, no bit
                    state_3      = 1'b1;
                    curr_path    = 1'b1;
                    track_length = 7'd3;
                end
                push_field({1'b1, tbl_char[i]}, tbl_name[i]);
                if (tbl_left[i] && (tbl_lefts[i] != 8'h00)) begin
                    push_field({1'b1, tbl_lefts[i]}, tbl_name[i]);
                end
                @(posedge clk);
                #1;
                char_found = 1'b0;
                if (tbl_noise[i]) begin
                    wait_idle(tbl_name[i]);
                    state_3      = 1'b0;
                    curr_path    = 1'b0;
                    track_length = 7'd0;
                end
            end
            k_back: begin
                state_3      = 1'b1;
                curr_path    = 1'b1;
                track_length = 7'd4;
                exp_bits.push_back(1'b0);
                exp_owner.push_back(tbl_name[i]);
                model_count++;
                @(posedge clk);
                #1;
                state_3      = 1'b0;
                curr_path    = 1'b0;
                track_length = 7'd0;
            end
            default: begin
                // pad the partial byte in the model, not counted
                while ((exp_bits.size() % 8) != 0) begin
                    exp_bits.push_back(1'b0);
                    exp_owner.push_back(tbl_name[i]);
                end
                flush = 1'b1;
                @(posedge clk);
                #1;
                flush = 1'b0;
                wait_flush_done(tbl_name[i]);
                if (timed_out) begin
                    return;
                end
                exp_count = model_count[count_width-1:0];
                checks++;
                assert (bit_count === exp_count) else begin
                    $display("error: %s bit_count expected %0d actual %0d",
                             tbl_name[i], exp_count, bit_count);
                    errors++;
                end
                assert (exp_bits.size() == 0) else begin
                    $display("%0d expected bits never came out before flush_done at %s",
                             exp_bits.size(), tbl_name[i]);
                    errors++;
                end
            end
        endcase
    endtask

    // compare each packed byte with the next 8 model bits
    always @(negedge clk) begin
        if (!rst && (byte_valid === 1'b1)) begin
            assert (exp_bits.size() >= 8) else begin
                $display("byte 0x%02h came out with no expected bits left", byte_data);
                errors++;
            end
            if (exp_bits.size() >= 8) begin
                col_exp = 8'h00;
                for (int k = 0; k < 8; k++) begin
                    col_exp   = {col_exp[6:0], exp_bits.pop_front()};
                    col_owner = exp_owner.pop_front();
                end
                checks++;
                assert (byte_data === col_exp) else begin
                    $display("error: %s expected 0x%02h actual 0x%02h",
                             col_owner, col_exp, byte_data);
                    errors++;
                end
            end
        end
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        char_found   = 1'b0;
        char_index   = 8'h00;
        curr_path    = 1'b0;
        track_length = 7'd0;
        state_3      = 1'b0;
        left         = 1'b0;
        num_lefts    = 8'h00;
        flush        = 1'b0;
        errors       = 0;
        checks       = 0;
        model_count  = 0;
        timed_out    = 1'b0;
        seed         = 91922;
        build_table();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; (i < tbl_kind.size()) && !timed_out; i++) begin
            apply_entry(i);
        end
        close_run();
    end

endmodule

/* run.sh */
#!/bin/bash
# build and run the header writer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module header_tb -f src.f -o header_sim \
    && ./obj_dir/header_sim > sim.log 2>&1 \
    || echo "build or simulation ended with an error"

cat sim.log 2> /dev/null
grep -qs "^TEST PASSED$" sim.log && exit 0 || exit 1

/* src.f */
design/huff_pkg.sv
design/header_synthesis.sv
design/bit_packer.sv
design/header_top.sv
dv/header_asserts.sv
dv/header_tb.sv
